/* bench/commit_checker.sv */
`timescale 1ns/1ps

module commit_checker (
    input logic               clk,
    input logic               reset_i,
    input logic               branch_0_i,
    input logic               branch_1_i,
    input logic               excp_i,
    input logic               ertn_i,
    input logic               flush_o,
    input cpu_pkg::word_t     next_pc_o,
    input cpu_pkg::word_t     csr_rdata_o,
    input cpu_pkg::word_t     rd_data_0_o,
    input cpu_pkg::word_t     rd_data_1_o,
    input cpu_pkg::word_t     rd_data_2_o,
    input cpu_pkg::word_t     rd_data_3_o,
    input cpu_pkg::word_t     debug0_wb_pc_o,
    input cpu_pkg::dbg_wen_t  debug0_wb_rf_wen_o,
    input cpu_pkg::reg_addr_t debug0_wb_rf_wnum_o,
    input cpu_pkg::word_t     debug0_wb_rf_wdata_o,
    input cpu_pkg::word_t     debug1_wb_pc_o,
    input cpu_pkg::dbg_wen_t  debug1_wb_rf_wen_o,
    input cpu_pkg::reg_addr_t debug1_wb_rf_wnum_o,
    input cpu_pkg::word_t     debug1_wb_rf_wdata_o
);
    import cpu_pkg::*;

    logic request;
    logic reset_seen = 1'b0;
    int   assert_failures = 0;

    assign request = branch_0_i | branch_1_i | excp_i | ertn_i;

    // Reset level at the previous edge
    always_ff @(posedge clk) begin
        reset_seen <= reset_i;
    end

    no_double_flush: assert property (@(posedge clk) disable iff (reset_i)
        flush_o |=> !flush_o)
        else begin
            $error("flush_o high on two consecutive cycles");
            assert_failures++;
        end

    flush_after_request: assert property (@(posedge clk) disable iff (reset_i)
        request |=> flush_o)
        else begin
            $error("flush_o missing one cycle after a redirect request");
            assert_failures++;
        end

    no_flush_without_request: assert property (@(posedge clk) disable iff (reset_i)
        !request |=> !flush_o)
        else begin
            $error("flush_o raised without a redirect request");
            assert_failures++;
        end

    wen_upper_zero: assert property (@(posedge clk) disable iff (reset_i)
        (debug0_wb_rf_wen_o[3:1] == 3'b000) && (debug1_wb_rf_wen_o[3:1] == 3'b000))
        else begin
            $error("debug wen upper bits not zero");
            assert_failures++;
        end

    zero_in_reset: assert property (@(posedge clk) (reset_i && reset_seen) |->
        (!flush_o && next_pc_o == '0 && csr_rdata_o == '0 &&
         (rd_data_0_o | rd_data_1_o | rd_data_2_o | rd_data_3_o) == '0 &&
         (debug0_wb_pc_o | debug0_wb_rf_wdata_o | debug1_wb_pc_o | debug1_wb_rf_wdata_o) == '0 &&
         debug0_wb_rf_wen_o == '0 && debug1_wb_rf_wen_o == '0 &&
         debug0_wb_rf_wnum_o == '0 && debug1_wb_rf_wnum_o == '0))
        else begin
            $error("outputs not zero during reset");
            assert_failures++;
        end

endmodule

bind commit_top commit_checker u_checker (.*);

/* bench/commit_monitor.sv */
`timescale 1ns/1ps

module commit_monitor (
    input logic clk
);
    import cpu_pkg::*;

    int    error_count  = 0;
    int    tests_passed = 0;
    int    tests_failed = 0;
    int    cur_test     = 0;
    bit    active       = 0;
    bit    test_bad     = 0;

    // Lane inputs of the previous checked cycle
    word_t     prev_pc [2]    = '{default: '0};
    dbg_wen_t  prev_wen [2]   = '{default: '0};
    reg_addr_t prev_wnum [2]  = '{default: '0};
    word_t     prev_wdata [2] = '{default: '0};

    task automatic check_word(input string name, input word_t expected, input word_t actual);
        if (expected !== actual) begin
            $display("** Error at %0t ns: %s expected %h, got %h",
                     $time, name, expected, actual);
            error_count++;
            test_bad = 1;
        end
    endtask

    // Report the running test and start counting the next one
    task automatic close_test();
        if (active) begin
            if (test_bad) begin
                tests_failed++;
                $display("Test %0d: FAIL", cur_test);
            end else begin
                tests_passed++;
                $display("Test %0d: pass", cur_test);
            end
            active = 0;
        end
    endtask

    always @(negedge clk) begin
        if (tb_commit.check_en) begin
            if (!active || tb_commit.exp_test != cur_test) begin
                close_test();
                cur_test = tb_commit.exp_test;
                test_bad = 0;
                active   = 1;
            end
            check_word("rd_data_0_o", tb_commit.exp_rd[0], tb_commit.rd_data[0]);
            check_word("rd_data_1_o", tb_commit.exp_rd[1], tb_commit.rd_data[1]);
            check_word("rd_data_2_o", tb_commit.exp_rd[2], tb_commit.rd_data[2]);
            check_word("rd_data_3_o", tb_commit.exp_rd[3], tb_commit.rd_data[3]);
            check_word("csr_rdata_o", tb_commit.exp_csr, tb_commit.csr_rdata_o);
            check_word("flush_o", {31'b0, tb_commit.exp_flush}, {31'b0, tb_commit.flush_o});
            check_word("next_pc_o", tb_commit.exp_npc, tb_commit.next_pc_o);

            // Trace lags the writeback inputs by one cycle
            check_word("debug0_wb_pc_o", prev_pc[0], tb_commit.dbg_pc[0]);
            check_word("debug0_wb_rf_wen_o", {28'b0, prev_wen[0]},
                       {28'b0, tb_commit.dbg_wen[0]});
            check_word("debug0_wb_rf_wnum_o", {27'b0, prev_wnum[0]},
                       {27'b0, tb_commit.dbg_wnum[0]});
            check_word("debug0_wb_rf_wdata_o", prev_wdata[0], tb_commit.dbg_wdata[0]);
            check_word("debug1_wb_pc_o", prev_pc[1], tb_commit.dbg_pc[1]);
            check_word("debug1_wb_rf_wen_o", {28'b0, prev_wen[1]},
                       {28'b0, tb_commit.dbg_wen[1]});
            check_word("debug1_wb_rf_wnum_o", {27'b0, prev_wnum[1]},
                       {27'b0, tb_commit.dbg_wnum[1]});
            check_word("debug1_wb_rf_wdata_o", prev_wdata[1], tb_commit.dbg_wdata[1]);

            prev_pc[0]    = tb_commit.wb_pc_0_i;
            prev_wen[0]   = {3'b000, tb_commit.wb_valid_0_i & tb_commit.wb_we_0_i};
            prev_wnum[0]  = tb_commit.wb_waddr_0_i;
            prev_wdata[0] = tb_commit.wb_wdata_0_i;
            prev_pc[1]    = tb_commit.wb_pc_1_i;
            prev_wen[1]   = {3'b000, tb_commit.wb_valid_1_i & tb_commit.wb_we_1_i};
            prev_wnum[1]  = tb_commit.wb_waddr_1_i;
            prev_wdata[1] = tb_commit.wb_wdata_1_i;
        end
    end

endmodule

/* bench/commit_trace.txt */
# test | lane0 v we pc waddr wdata | lane1 same | rd addr 0-3 | csr we waddr wdata raddr
# redirect b0 tgt0 b1 tgt1 excp refill epc ertn | expect rd0-rd3 csr_rdata flush next_pc
1 1 1 100 0 55 1 1 104 1 R 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0
1 1 1 108 2 R 1 1 10c 3 R 0 1 2 3 0 0 0 0 0 0 0 0 0 0 0 0 0 R0 0 0 0 0 0
1 1 1 110 4 R 1 1 114 4 R 1 2 3 0 0 0 0 0 0 0 0 0 0 0 0 0 R0 R1 R2 0 0 0 0
1 1 0 118 5 77 0 1 11c 6 88 4 0 1 2 0 0 0 0 0 0 0 0 0 0 0 0 R4 0 R0 R1 0 0 0
1 0 0 0 0 0 0 0 0 0 0 5 6 4 3 0 0 0 0 0 0 0 0 0 0 0 0 0 0 R4 R2 0 0 0
2 0 0 0 0 0 0 0 0 0 0 0 0 0 0 1 6 1234 6 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0
2 0 0 0 0 0 0 0 0 0 0 0 0 0 0 1 c 1c0017f 6 0 0 0 0 0 0 0 0 0 0 0 0 1234 0 0
2 0 0 0 0 0 0 0 0 0 0 0 0 0 0 1 88 abcd c 0 0 0 0 0 0 0 0 0 0 0 0 1c00140 0 0
2 0 0 0 0 0 0 0 0 0 0 0 0 0 0 1 20 ffff 88 0 0 0 0 0 0 0 0 0 0 0 0 abc0 0 0
2 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 20 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0
3 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 1 200 1 300 0 0 0 0 0 0 0 0 0 0 0
3 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 1 200
3 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 1 300 0 0 0 0 0 0 0 0 0 0 200
3 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 1 300
3 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 300
4 0 0 0 0 0 0 0 0 0 0 0 0 0 0 1 6 999 6 0 0 0 0 1 0 500 0 0 0 0 0 1234 0 300
4 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 6 0 0 0 0 0 0 0 0 0 0 0 0 500 1 1c00140
4 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 6 0 0 0 0 1 1 600 0 0 0 0 0 500 0 1c00140
4 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 6 0 0 0 0 0 0 0 0 0 0 0 0 600 1 abc0
4 0 0 0 0 0 0 0 0 0 0 0 0 0 0 1 c 2000 c 0 0 0 0 1 0 700 0 0 0 0 0 1c00140 0 abc0
4 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 c 0 0 0 0 0 0 0 0 0 0 0 0 2000 1 1c00140
5 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 6 0 0 0 0 0 0 0 1 0 0 0 0 700 0 1c00140
5 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 6 0 0 0 0 0 0 0 0 0 0 0 0 700 1 700
5 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 6 0 0 1 340 0 0 0 1 0 0 0 0 700 0 700
5 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 6 0 0 0 0 0 0 0 0 0 0 0 0 700 1 340
6 1 0 800 7 R 0 0 804 8 9 7 8 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 340
6 1 1 808 7 11 1 1 80c 8 R 7 8 4 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 R4 0 0 0 340
6 0 0 0 0 0 0 0 0 0 0 7 8 0 0 0 0 0 0 0 0 0 0 0 0 0 0 11 R6 0 0 0 0 340
6 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 340

/* bench/tb_commit.sv */
`timescale 1ns/1ps

module tb_commit;
    import cpu_pkg::*;

    localparam int TOKENS    = 34;
    localparam int MAX_LINES = 200;
    localparam int TIMEOUT   = 1000;

    logic clk = 1'b0;
    logic reset_i;
    logic wb_valid_0_i, wb_we_0_i, wb_valid_1_i, wb_we_1_i;
    word_t wb_pc_0_i, wb_wdata_0_i, wb_pc_1_i, wb_wdata_1_i;
    reg_addr_t wb_waddr_0_i, wb_waddr_1_i;
    reg_addr_t rd_addr [4];
    word_t rd_data [4];
    logic csr_we_i;
    csr_addr_t csr_waddr_i, csr_raddr_i;
    word_t csr_wdata_i, csr_rdata_o;
    logic branch_0_i, branch_1_i, excp_i, excp_tlbrefill_i, ertn_i;
    word_t branch_target_0_i, branch_target_1_i, excp_pc_i;
    logic flush_o;
    word_t next_pc_o;
    word_t dbg_pc [2], dbg_wdata [2];
    dbg_wen_t dbg_wen [2];
    reg_addr_t dbg_wnum [2];

    // Expected values of the current trace line
    logic  check_en = 1'b0;
    int    exp_test;
    word_t exp_rd [4];
    word_t exp_csr;
    logic  exp_flush;
    word_t exp_npc;

    int          fd;
    int          lines;
    string       tok [TOKENS];
    word_t       val [TOKENS];
    word_t       rand_words [$];
    logic [31:0] lfsr_state;

    always #4 clk = ~clk;

    commit_top UUT (
        .clk(clk), .reset_i(reset_i),
        .wb_valid_0_i(wb_valid_0_i), .wb_we_0_i(wb_we_0_i), .wb_pc_0_i(wb_pc_0_i),
        .wb_waddr_0_i(wb_waddr_0_i), .wb_wdata_0_i(wb_wdata_0_i),
        .wb_valid_1_i(wb_valid_1_i), .wb_we_1_i(wb_we_1_i), .wb_pc_1_i(wb_pc_1_i),
        .wb_waddr_1_i(wb_waddr_1_i), .wb_wdata_1_i(wb_wdata_1_i),
        .rd_addr_0_i(rd_addr[0]), .rd_addr_1_i(rd_addr[1]),
        .rd_addr_2_i(rd_addr[2]), .rd_addr_3_i(rd_addr[3]),
        .rd_data_0_o(rd_data[0]), .rd_data_1_o(rd_data[1]),
        .rd_data_2_o(rd_data[2]), .rd_data_3_o(rd_data[3]),
        .csr_we_i(csr_we_i), .csr_waddr_i(csr_waddr_i), .csr_wdata_i(csr_wdata_i),
        .csr_raddr_i(csr_raddr_i), .csr_rdata_o(csr_rdata_o),
        .branch_0_i(branch_0_i), .branch_target_0_i(branch_target_0_i),
        .branch_1_i(branch_1_i), .branch_target_1_i(branch_target_1_i),
        .excp_i(excp_i), .excp_tlbrefill_i(excp_tlbrefill_i), .excp_pc_i(excp_pc_i),
        .ertn_i(ertn_i), .flush_o(flush_o), .next_pc_o(next_pc_o),
        .debug0_wb_pc_o(dbg_pc[0]), .debug0_wb_rf_wen_o(dbg_wen[0]),
        .debug0_wb_rf_wnum_o(dbg_wnum[0]), .debug0_wb_rf_wdata_o(dbg_wdata[0]),
        .debug1_wb_pc_o(dbg_pc[1]), .debug1_wb_rf_wen_o(dbg_wen[1]),
        .debug1_wb_rf_wnum_o(dbg_wnum[1]), .debug1_wb_rf_wdata_o(dbg_wdata[1])
    );

    commit_monitor u_monitor (.clk(clk));

    // Galois form, taps of x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
    endfunction

    task automatic next_random_word(output word_t w);
        for (int b = 0; b < 32; b++) begin
            w = {w[30:0], lfsr_state[0]};
            lfsr_state = lfsr_step(lfsr_state);
        end
        rand_words.push_back(w);
    endtask

    // Skips comment lines, returns 0 at end of file
    task automatic read_line(output bit got_line);
        string t;
        string rest;
        int    code;
        bit    done;
        got_line = 0;
        done = 0;
        while (!done) begin
            code = $fscanf(fd, "%s", t);
            if (code != 1) begin
                done = 1;
            end else if (t.getc(0) == 8'h23) begin
                code = $fgets(rest, fd);
            end else begin
                tok[0] = t;
                for (int i = 1; i < TOKENS; i++) begin
                    code = $fscanf(fd, "%s", tok[i]);
                end
                got_line = 1;
                done = 1;
            end
        end
    endtask

    // R draws a new random word, Rk names the k-th word drawn
    task automatic resolve_tokens();
        word_t w;
        for (int i = 0; i < TOKENS; i++) begin
            if (tok[i] == "R") begin
                next_random_word(w);
                val[i] = w;
            end else if (tok[i].getc(0) == 8'h52) begin
                val[i] = rand_words[tok[i].substr(1, tok[i].len() - 1).atoi()];
            end else begin
                val[i] = tok[i].atohex();
            end
        end
    endtask

    task automatic drive_line();
        wb_valid_0_i <= val[1][0];
        wb_we_0_i    <= val[2][0];
        wb_pc_0_i    <= val[3];
        wb_waddr_0_i <= val[4][4:0];
        wb_wdata_0_i <= val[5];
        wb_valid_1_i <= val[6][0];
        wb_we_1_i    <= val[7][0];
        wb_pc_1_i    <= val[8];
        wb_waddr_1_i <= val[9][4:0];
        wb_wdata_1_i <= val[10];
        for (int i = 0; i < 4; i++) begin
            rd_addr[i] <= val[11 + i][4:0];
            exp_rd[i]  <= val[27 + i];
        end
        csr_we_i          <= val[15][0];
        csr_waddr_i       <= val[16][13:0];
        csr_wdata_i       <= val[17];
        csr_raddr_i       <= val[18][13:0];
        branch_0_i        <= val[19][0];
        branch_target_0_i <= val[20];
        branch_1_i        <= val[21][0];
        branch_target_1_i <= val[22];
        excp_i            <= val[23][0];
        excp_tlbrefill_i  <= val[24][0];
        excp_pc_i         <= val[25];
        ertn_i            <= val[26][0];
        exp_test          <= val[0];
        exp_csr           <= val[31];
        exp_flush         <= val[32][0];
        exp_npc           <= val[33];
        check_en          <= 1'b1;
    endtask

    initial begin
        for (int cycles = 0; cycles < TIMEOUT; cycles++) begin
            @(posedge clk);
        end
        $display("Timeout: run did not finish within %0d cycles", TIMEOUT);
        $display("Something failed");
        $finish;
    end

    initial begin
        bit got_line;
        bit overrun;
        reset_i = 1'b1;
        lfsr_state = 32'h21750c89;
        overrun = 0;
        for (int i = 0; i < TOKENS; i++) begin
            val[i] = '0;
        end
        drive_line();
        check_en <= 1'b0;
        fd = $fopen("bench/commit_trace.txt", "r");
        repeat (3) @(posedge clk);
        reset_i <= 1'b0;
        lines = 0;
        got_line = (fd != 0);
        while (got_line && lines < MAX_LINES) begin
            read_line(got_line);
            if (got_line) begin
                resolve_tokens();
                @(posedge clk);
                drive_line();
                lines++;
            end
        end
        if (got_line) begin
            overrun = 1;
            $display("Trace file has more lines than the limit of %0d", MAX_LINES);
        end
        @(posedge clk);
        check_en <= 1'b0;
        u_monitor.close_test();
        if (fd == 0) begin
            $display("Could not open the trace file bench/commit_trace.txt");
        end else begin
            $fclose(fd);
        end
        $display("Lines %0d, passed %0d, failed %0d, value errors %0d, assertion errors %0d",
                 lines, u_monitor.tests_passed, u_monitor.tests_failed,
                 u_monitor.error_count, UUT.u_checker.assert_failures);
        if (fd != 0 && lines > 0 && !overrun && u_monitor.error_count == 0 &&
            UUT.u_checker.assert_failures == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

/* compile.f */
+incdir+design
design/cpu_pkg.sv
design/gpr_file.sv
design/redirect_csr.sv
design/redirect_unit.sv
design/commit_trace.sv
design/commit_top.sv
bench/commit_checker.sv
bench/commit_monitor.sv
bench/tb_commit.sv

/* design/commit_top.sv */
`timescale 1ns/1ps
`include "cpu_defs.svh"

module commit_top (
    input  logic               clk,
    input  logic               reset_i,

    // Writeback lane 0
    input  logic               wb_valid_0_i,
    input  logic               wb_we_0_i,
    input  cpu_pkg::word_t     wb_pc_0_i,
    input  cpu_pkg::reg_addr_t wb_waddr_0_i,
    input  cpu_pkg::word_t     wb_wdata_0_i,

    // Writeback lane 1
    input  logic               wb_valid_1_i,
    input  logic               wb_we_1_i,
    input  cpu_pkg::word_t     wb_pc_1_i,
    input  cpu_pkg::reg_addr_t wb_waddr_1_i,
    input  cpu_pkg::word_t     wb_wdata_1_i,

    // Register reads for issue
    input  cpu_pkg::reg_addr_t rd_addr_0_i,
    input  cpu_pkg::reg_addr_t rd_addr_1_i,
    input  cpu_pkg::reg_addr_t rd_addr_2_i,
    input  cpu_pkg::reg_addr_t rd_addr_3_i,
    output cpu_pkg::word_t     rd_data_0_o,
    output cpu_pkg::word_t     rd_data_1_o,
    output cpu_pkg::word_t     rd_data_2_o,
    output cpu_pkg::word_t     rd_data_3_o,

    // CSR access
    input  logic               csr_we_i,
    input  cpu_pkg::csr_addr_t csr_waddr_i,
    input  cpu_pkg::word_t     csr_wdata_i,
    input  cpu_pkg::csr_addr_t csr_raddr_i,
    output cpu_pkg::word_t     csr_rdata_o,

    // Redirect requests
    input  logic               branch_0_i,
    input  cpu_pkg::word_t     branch_target_0_i,
    input  logic               branch_1_i,
    input  cpu_pkg::word_t     branch_target_1_i,
    input  logic               excp_i,
    input  logic               excp_tlbrefill_i,
    input  cpu_pkg::word_t     excp_pc_i,
    input  logic               ertn_i,

    output logic               flush_o,
    output cpu_pkg::word_t     next_pc_o,

    // Commit trace
    output cpu_pkg::word_t     debug0_wb_pc_o,
    output cpu_pkg::dbg_wen_t  debug0_wb_rf_wen_o,
    output cpu_pkg::reg_addr_t debug0_wb_rf_wnum_o,
    output cpu_pkg::word_t     debug0_wb_rf_wdata_o,
    output cpu_pkg::word_t     debug1_wb_pc_o,
    output cpu_pkg::dbg_wen_t  debug1_wb_rf_wen_o,
    output cpu_pkg::reg_addr_t debug1_wb_rf_wnum_o,
    output cpu_pkg::word_t     debug1_wb_rf_wdata_o
);
    import cpu_pkg::*;

    // CSR block to redirect unit
    word_t eentry;
    word_t tlbrentry;
    word_t era;

    gpr_file #(
        .READ_PORTS(`GPR_READ_PORTS)
    ) u_gpr_file (
        .clk      (clk),
        .reset_i  (reset_i),
        .wen_0_i  (wb_valid_0_i & wb_we_0_i),
        .waddr_0_i(wb_waddr_0_i),
        .wdata_0_i(wb_wdata_0_i),
        .wen_1_i  (wb_valid_1_i & wb_we_1_i),
        .waddr_1_i(wb_waddr_1_i),
        .wdata_1_i(wb_wdata_1_i),
        .raddr_0_i(rd_addr_0_i),
        .raddr_1_i(rd_addr_1_i),
        .raddr_2_i(rd_addr_2_i),
        .raddr_3_i(rd_addr_3_i),
        .rdata_0_o(rd_data_0_o),
        .rdata_1_o(rd_data_1_o),
        .rdata_2_o(rd_data_2_o),
        .rdata_3_o(rd_data_3_o)
    );

    redirect_csr u_redirect_csr (
        .clk        (clk),
        .reset_i    (reset_i),
        .csr_we_i   (csr_we_i),
        .csr_waddr_i(csr_waddr_i),
        .csr_wdata_i(csr_wdata_i),
        .csr_raddr_i(csr_raddr_i),
        .csr_rdata_o(csr_rdata_o),
        .excp_i     (excp_i),
        .excp_pc_i  (excp_pc_i),
        .eentry_o   (eentry),
        .tlbrentry_o(tlbrentry),
        .era_o      (era)
    );

    redirect_unit u_redirect_unit (
        .clk              (clk),
        .reset_i          (reset_i),
        .branch_0_i       (branch_0_i),
        .branch_target_0_i(branch_target_0_i),
        .branch_1_i       (branch_1_i),
        .branch_target_1_i(branch_target_1_i),
        .excp_i           (excp_i),
        .excp_tlbrefill_i (excp_tlbrefill_i),
        .ertn_i           (ertn_i),
        .eentry_i         (eentry),
        .tlbrentry_i      (tlbrentry),
        .era_i            (era),
        .flush_o          (flush_o),
        .next_pc_o        (next_pc_o)
    );

    commit_trace u_commit_trace (
        .clk                 (clk),
        .reset_i             (reset_i),
        .valid_0_i           (wb_valid_0_i),
        .we_0_i              (wb_we_0_i),
        .pc_0_i              (wb_pc_0_i),
        .waddr_0_i           (wb_waddr_0_i),
        .wdata_0_i           (wb_wdata_0_i),
        .valid_1_i           (wb_valid_1_i),
        .we_1_i              (wb_we_1_i),
        .pc_1_i              (wb_pc_1_i),
        .waddr_1_i           (wb_waddr_1_i),
        .wdata_1_i           (wb_wdata_1_i),
        .debug0_wb_pc_o      (debug0_wb_pc_o),
        .debug0_wb_rf_wen_o  (debug0_wb_rf_wen_o),
        .debug0_wb_rf_wnum_o (debug0_wb_rf_wnum_o),
        .debug0_wb_rf_wdata_o(debug0_wb_rf_wdata_o),
        .debug1_wb_pc_o      (debug1_wb_pc_o),
        .debug1_wb_rf_wen_o  (debug1_wb_rf_wen_o),
        .debug1_wb_rf_wnum_o (debug1_wb_rf_wnum_o),
        .debug1_wb_rf_wdata_o(debug1_wb_rf_wdata_o)
    );

endmodule

/* design/commit_trace.sv */
`timescale 1ns/1ps

module commit_trace (
    input  logic               clk,
    input  logic               reset_i,

    // Lane 0 commit
    input  logic               valid_0_i,
    input  logic               we_0_i,
    input  cpu_pkg::word_t     pc_0_i,
    input  cpu_pkg::reg_addr_t waddr_0_i,
    input  cpu_pkg::word_t     wdata_0_i,

    // Lane 1 commit
    input  logic               valid_1_i,
    input  logic               we_1_i,
    input  cpu_pkg::word_t     pc_1_i,
    input  cpu_pkg::reg_addr_t waddr_1_i,
    input  cpu_pkg::word_t     wdata_1_i,

    // Trace outputs for the external comparator
    output cpu_pkg::word_t     debug0_wb_pc_o,
    output cpu_pkg::dbg_wen_t  debug0_wb_rf_wen_o,
    output cpu_pkg::reg_addr_t debug0_wb_rf_wnum_o,
    output cpu_pkg::word_t     debug0_wb_rf_wdata_o,
    output cpu_pkg::word_t     debug1_wb_pc_o,
    output cpu_pkg::dbg_wen_t  debug1_wb_rf_wen_o,
    output cpu_pkg::reg_addr_t debug1_wb_rf_wnum_o,
    output cpu_pkg::word_t     debug1_wb_rf_wdata_o
);
    import cpu_pkg::*;

    dbg_wen_t wen_0;
    dbg_wen_t wen_1;

    // Only bit 0 carries the lane's write
    assign wen_0 = {3'b000, valid_0_i & we_0_i};
    assign wen_1 = {3'b000, valid_1_i & we_1_i};

    always_ff @(posedge clk) begin
        if (reset_i) begin
            debug0_wb_pc_o       <= '0;
            debug0_wb_rf_wen_o   <= '0;
            debug0_wb_rf_wnum_o  <= '0;
            debug0_wb_rf_wdata_o <= '0;
            debug1_wb_pc_o       <= '0;
            debug1_wb_rf_wen_o   <= '0;
            debug1_wb_rf_wnum_o  <= '0;
            debug1_wb_rf_wdata_o <= '0;
        end else begin
            debug0_wb_pc_o       <= pc_0_i;
            debug0_wb_rf_wen_o   <= wen_0;
            debug0_wb_rf_wnum_o  <= waddr_0_i;
            debug0_wb_rf_wdata_o <= wdata_0_i;
            debug1_wb_pc_o       <= pc_1_i;
            debug1_wb_rf_wen_o   <= wen_1;
            debug1_wb_rf_wnum_o  <= waddr_1_i;
            debug1_wb_rf_wdata_o <= wdata_1_i;
        end
    end

endmodule

/* design/cpu_defs.svh */
`ifndef CPU_DEFS_SVH
`define CPU_DEFS_SVH

// CSR addresses decoded by the CSR block
`define CSR_ADDR_ERA        14'd6
`define CSR_ADDR_EENTRY     14'd12
`define CSR_ADDR_TLBRENTRY  14'd136

// General register file geometry
`define GPR_COUNT           32
`define GPR_READ_PORTS      4

// Low bits of the entry CSRs that always read as zero
`define ENTRY_ALIGN_BITS    6

`endif

/* design/cpu_pkg.sv */
package cpu_pkg;

    // Data or address word
    typedef logic [31:0] word_t;

    // General register number
    typedef logic [4:0] reg_addr_t;

    // CSR address space
    typedef logic [13:0] csr_addr_t;

    // Debug write enable, one bit per byte lane in the trace format;
    // only bit 0 is ever set by this core
    typedef logic [3:0] dbg_wen_t;

endpackage

/* design/gpr_file.sv */
`timescale 1ns/1ps
`include "cpu_defs.svh"

module gpr_file #(
    parameter int READ_PORTS = `GPR_READ_PORTS
) (
    input  logic               clk,
    input  logic               reset_i,

    // Write lanes, lane 1 is the younger instruction
    input  logic               wen_0_i,
    input  cpu_pkg::reg_addr_t waddr_0_i,
    input  cpu_pkg::word_t     wdata_0_i,
    input  logic               wen_1_i,
    input  cpu_pkg::reg_addr_t waddr_1_i,
    input  cpu_pkg::word_t     wdata_1_i,

    // Read ports
    input  cpu_pkg::reg_addr_t raddr_0_i,
    input  cpu_pkg::reg_addr_t raddr_1_i,
    input  cpu_pkg::reg_addr_t raddr_2_i,
    input  cpu_pkg::reg_addr_t raddr_3_i,
    output cpu_pkg::word_t     rdata_0_o,
    output cpu_pkg::word_t     rdata_1_o,
    output cpu_pkg::word_t     rdata_2_o,
    output cpu_pkg::word_t     rdata_3_o
);
    import cpu_pkg::*;

    word_t     regs [`GPR_COUNT];
    reg_addr_t raddr [READ_PORTS];
    word_t     rdata [READ_PORTS];

    // Lane 1 is applied last so it wins a same-register collision
    always_ff @(posedge clk) begin
        if (reset_i) begin
            for (int i = 0; i < `GPR_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else begin
            if (wen_0_i && (waddr_0_i != '0)) begin
                regs[waddr_0_i] <= wdata_0_i;
            end
            if (wen_1_i && (waddr_1_i != '0)) begin
                regs[waddr_1_i] <= wdata_1_i;
            end
        end
    end

    assign raddr[0] = raddr_0_i;
    assign raddr[1] = raddr_1_i;
    assign raddr[2] = raddr_2_i;
    assign raddr[3] = raddr_3_i;

    // No write-through, a write shows up one cycle later
    for (genvar g = 0; g < READ_PORTS; g++) begin : g_read
        assign rdata[g] = (raddr[g] == '0) ? '0 : regs[raddr[g]];
    end

    assign rdata_0_o = rdata[0];
    assign rdata_1_o = rdata[1];
    assign rdata_2_o = rdata[2];
    assign rdata_3_o = rdata[3];

endmodule

/* design/redirect_csr.sv */
`timescale 1ns/1ps
`include "cpu_defs.svh"

module redirect_csr (
    input  logic               clk,
    input  logic               reset_i,

    // Software access
    input  logic               csr_we_i,
    input  cpu_pkg::csr_addr_t csr_waddr_i,
    input  cpu_pkg::word_t     csr_wdata_i,
    input  cpu_pkg::csr_addr_t csr_raddr_i,
    output cpu_pkg::word_t     csr_rdata_o,

    // Exception capture
    input  logic               excp_i,
    input  cpu_pkg::word_t     excp_pc_i,

    // Current contents for the redirect unit
    output cpu_pkg::word_t     eentry_o,
    output cpu_pkg::word_t     tlbrentry_o,
    output cpu_pkg::word_t     era_o
);
    import cpu_pkg::*;

    word_t era_q;
    word_t eentry_q;
    word_t tlbrentry_q;

    // Entry points sit on a 64-byte boundary
    function automatic word_t entry_align(input word_t value);
        return {value[31:`ENTRY_ALIGN_BITS], {`ENTRY_ALIGN_BITS{1'b0}}};
    endfunction

    always_ff @(posedge clk) begin
        if (reset_i) begin
            era_q       <= '0;
            eentry_q    <= '0;
            tlbrentry_q <= '0;
        end else begin
            if (csr_we_i) begin
                case (csr_waddr_i)
                    `CSR_ADDR_ERA:       era_q       <= csr_wdata_i;
                    `CSR_ADDR_EENTRY:    eentry_q    <= entry_align(csr_wdata_i);
                    `CSR_ADDR_TLBRENTRY: tlbrentry_q <= entry_align(csr_wdata_i);
                    default: ;
                endcase
            end
            // Faulting PC overrides a software write to ERA in the same cycle
            if (excp_i) begin
                era_q <= excp_pc_i;
            end
        end
    end

    // Unknown addresses read as zero
    always_comb begin
        case (csr_raddr_i)
            `CSR_ADDR_ERA:       csr_rdata_o = era_q;
            `CSR_ADDR_EENTRY:    csr_rdata_o = eentry_q;
            `CSR_ADDR_TLBRENTRY: csr_rdata_o = tlbrentry_q;
            default:             csr_rdata_o = '0;
        endcase
    end

    assign eentry_o    = eentry_q;
    assign tlbrentry_o = tlbrentry_q;
    assign era_o       = era_q;

endmodule

/* design/redirect_unit.sv */
`timescale 1ns/1ps

module redirect_unit (
    input  logic           clk,
    input  logic           reset_i,

    // Redirect requests
    input  logic           branch_0_i,
    input  cpu_pkg::word_t branch_target_0_i,
    input  logic           branch_1_i,
    input  cpu_pkg::word_t branch_target_1_i,
    input  logic           excp_i,
    input  logic           excp_tlbrefill_i,
    input  logic           ertn_i,

    // CSR contents before this edge
    input  cpu_pkg::word_t eentry_i,
    input  cpu_pkg::word_t tlbrentry_i,
    input  cpu_pkg::word_t era_i,

    output logic           flush_o,
    output cpu_pkg::word_t next_pc_o
);
    import cpu_pkg::*;

    logic  redirect;
    word_t target;

    assign redirect = branch_0_i | branch_1_i | excp_i | ertn_i;

    // Older lane first, then exception, then return
    always_comb begin
        if (branch_0_i) begin
            target = branch_target_0_i;
        end else if (branch_1_i) begin
            target = branch_target_1_i;
        end else if (excp_i) begin
            target = excp_tlbrefill_i ? tlbrentry_i : eentry_i;
        end else if (ertn_i) begin
            target = era_i;
        end else begin
            target = '0;
        end
    end

    // next_pc_o keeps the last target between redirects
    always_ff @(posedge clk) begin
        if (reset_i) begin
            flush_o   <= 1'b0;
            next_pc_o <= '0;
        end else begin
            flush_o <= redirect;
            if (redirect) begin
                next_pc_o <= target;
            end
        end
    end

endmodule
